/* tawas_lsu.f */
source/tawas_pkg.sv
source/tawas_ls_if.sv
source/tawas_ls.sv
source/tawas_dram.sv
source/tawas_axi.sv
source/tawas_ld_rtn.sv
source/tawas_lsu.sv
tests/tb_clk.sv
tests/tb_tawas_lsu.sv

/* run.sh */
#!/bin/sh
# Compile and run the load/store unit testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert \
  --top-module tb_tawas_lsu \
  -f tawas_lsu.f \
  -o sim_tawas_lsu
./obj_dir/sim_tawas_lsu

/* tests/tb_tawas_lsu.sv */
// Random-stimulus testbench for the load/store unit, with an AXI4-Lite slave
// model, a reference memory model and typed compare tasks.
module tb_tawas_lsu;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int dram_words = 256;
  localparam int total_ops = dram_words + 2000;
  localparam int max_cycles = 200000;
  localparam int stall_limit = 400;

  logic clk, rst;
  logic op_valid, op_write;
  tawas_pkg::slice_t op_slice, load_slice, last_served;
  tawas_pkg::word_t op_addr, op_data, load_data, awaddr, wdata, araddr, rdata;
  tawas_pkg::mask_t op_mask, wstrb;
  tawas_pkg::reg_sel_t op_reg, load_reg;
  logic [3:0] stall;
  logic load_valid, awvalid, awready, wvalid, wready, bvalid, bready;
  logic arvalid, arready, rvalid, rready;
  logic [1:0] bresp, rresp;

  integer seed = 32'h14c1;
  int cyc = 0;
  int issued = 0;
  int done_ops = 0;
  tawas_pkg::word_t lmem [dram_words];
  tawas_pkg::word_t amem [64];

  // Per-slice AXI request as the model sees it
  logic [3:0] pend, pend_write, started;
  tawas_pkg::word_t pend_addr [4];
  tawas_pkg::word_t pend_data [4];
  tawas_pkg::mask_t pend_mask [4];
  tawas_pkg::reg_sel_t pend_reg [4];
  tawas_pkg::word_t r_exp [4];
  int acc_edge [4];
  int stall_age [4];

  // Slices of AXI read results in the order the R channel delivered them
  tawas_pkg::slice_t rq [$];

  // Local loads waiting for their fixed-latency result
  int lq_due [$];
  tawas_pkg::slice_t lq_slice [$];
  tawas_pkg::reg_sel_t lq_reg [$];
  tawas_pkg::word_t lq_data [$];

  // Slave channel state
  int aw_cnt, w_cnt, ar_cnt, b_cnt, r_cnt;
  logic aw_have, w_have, b_wait, r_wait, addr_v_prev;
  logic [5:0] aw_idx;
  tawas_pkg::word_t w_d;
  tawas_pkg::mask_t w_s;

  tb_clk clk_gen (.clk(clk), .rst(rst));

  tawas_lsu #(.dram_words(dram_words)) dut0 (
    .clk(clk), .rst(rst),
    .op_valid(op_valid), .op_slice(op_slice), .op_write(op_write),
    .op_addr(op_addr), .op_data(op_data), .op_mask(op_mask), .op_reg(op_reg),
    .stall(stall),
    .load_valid(load_valid), .load_slice(load_slice), .load_reg(load_reg),
    .load_data(load_data),
    .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
    .bresp(bresp), .bvalid(bvalid), .bready(bready),
    .araddr(araddr), .arvalid(arvalid), .arready(arready),
    .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready)
  );

  always @(posedge clk) cyc <= cyc + 1;

  task automatic abort_run(input string what);
    $display("%s at %0t", what, $time);
    $display("SIMULATION FAILED");
    $fatal(1, "run aborted");
  endtask

  task automatic check_word(input string name, input tawas_pkg::word_t exp,
                            input tawas_pkg::word_t act);
    if (act !== exp) begin
      $display("ERROR %0t %s expected %h actual %h", $time, name, exp, act);
      $display("SIMULATION FAILED");
      $fatal(1, "word mismatch");
    end
  endtask

  task automatic check_mask(input string name, input tawas_pkg::mask_t exp,
                            input tawas_pkg::mask_t act);
    if (act !== exp) begin
      $display("ERROR %0t %s expected %h actual %h", $time, name, exp, act);
      $display("SIMULATION FAILED");
      $fatal(1, "mask mismatch");
    end
  endtask

  task automatic check_slice(input string name, input tawas_pkg::slice_t exp,
                             input tawas_pkg::slice_t act);
    if (act !== exp) begin
      $display("ERROR %0t %s expected %0d actual %0d", $time, name, exp, act);
      $display("SIMULATION FAILED");
      $fatal(1, "slice mismatch");
    end
  endtask

  task automatic check_reg(input string name, input tawas_pkg::reg_sel_t exp,
                           input tawas_pkg::reg_sel_t act);
    if (act !== exp) begin
      $display("ERROR %0t %s expected %0d actual %0d", $time, name, exp, act);
      $display("SIMULATION FAILED");
      $fatal(1, "register mismatch");
    end
  endtask

  task automatic check_stall(input logic [3:0] exp, input logic [3:0] act);
    if (act !== exp) begin
      $display("ERROR %0t stall expected %b actual %b", $time, exp, act);
      $display("SIMULATION FAILED");
      $fatal(1, "stall mismatch");
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERROR %0t %s expected %b actual %b", $time, name, exp, act);
      $display("SIMULATION FAILED");
      $fatal(1, "bit mismatch");
    end
  endtask

  function automatic int rand_below(input int n);
    int unsigned r;
    r = $unsigned($random(seed));
    return int'(r % n);
  endfunction

  function automatic tawas_pkg::word_t merge_bytes(input tawas_pkg::word_t old,
      input tawas_pkg::word_t nw, input tawas_pkg::mask_t m);
    tawas_pkg::word_t res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (m[b]) res[8*b +: 8] = nw[8*b +: 8];
    end
    return res;
  endfunction

  // Results of the edge just passed: writeback port and stall vector
  task automatic check_results();
    tawas_pkg::slice_t s;
    if (lq_due.size() > 0 && lq_due[0] == cyc) begin
      check_bit("load_valid", 1'b1, load_valid);
      check_slice("load_slice", lq_slice[0], load_slice);
      check_reg("load_reg", lq_reg[0], load_reg);
      check_word("load_data", lq_data[0], load_data);
      void'(lq_due.pop_front());
      void'(lq_slice.pop_front());
      void'(lq_reg.pop_front());
      void'(lq_data.pop_front());
      done_ops++;
    end else if (load_valid) begin
      if (rq.size() == 0) begin
        abort_run("Load result with no AXI load in flight");
      end
      s = rq.pop_front();
      check_slice("load_slice", s, load_slice);
      check_reg("load_reg", pend_reg[s], load_reg);
      check_word("load_data", r_exp[s], load_data);
      pend[s] = 1'b0;
      done_ops++;
    end
    check_stall(pend, stall);
    for (int i = 0; i < 4; i++) begin
      stall_age[i] = stall[i] ? stall_age[i] + 1 : 0;
      if (stall_age[i] > stall_limit) abort_run("A stall bit never cleared");
    end
  endtask

  // A new transaction must come from the next eligible slot in rotation
  task automatic start_transaction();
    tawas_pkg::slice_t c, exp;
    logic found;
    found = 1'b0;
    exp = last_served;
    for (int i = 1; i <= 4; i++) begin
      c = tawas_pkg::slice_t'(int'(last_served) + i);
      if (!found && pend[c] && !started[c] && acc_edge[c] <= cyc - 2) begin
        found = 1'b1;
        exp = c;
      end
    end
    if (!found) abort_run("AXI transaction started with no eligible slot");
    check_bit("awvalid", pend_write[exp], awvalid);
    check_bit("arvalid", !pend_write[exp], arvalid);
    if (pend_write[exp]) begin
      check_slice("served slice", exp, tawas_pkg::slice_t'(awaddr[3:2]));
      check_word("awaddr", pend_addr[exp], awaddr);
    end else begin
      check_slice("served slice", exp, tawas_pkg::slice_t'(araddr[3:2]));
      check_word("araddr", pend_addr[exp], araddr);
    end
    started[exp] = 1'b1;
    last_served = exp;
  endtask

  // AXI4-Lite slave: decides readies and valids for the coming edge
  task automatic drive_slave();
    if ((awvalid || arvalid) && !addr_v_prev) start_transaction();
    addr_v_prev = awvalid || arvalid;
    awready = awvalid && aw_cnt == 0;
    if (awvalid && aw_cnt != 0) aw_cnt--;
    if (awvalid && awready) begin
      aw_have = 1'b1;
      aw_idx = awaddr[7:2];
      aw_cnt = rand_below(4);
    end
    wready = wvalid && w_cnt == 0;
    if (wvalid && w_cnt != 0) w_cnt--;
    if (wvalid && wready) begin
      check_word("wdata", pend_data[last_served], wdata);
      check_mask("wstrb", pend_mask[last_served], wstrb);
      w_have = 1'b1;
      w_d = wdata;
      w_s = wstrb;
      w_cnt = rand_below(4);
    end
    if (aw_have && w_have && !b_wait) begin
      amem[aw_idx] = merge_bytes(amem[aw_idx], w_d, w_s);
      aw_have = 1'b0;
      w_have = 1'b0;
      b_wait = 1'b1;
      b_cnt = rand_below(4);
    end
    if (b_wait) begin
      if (b_cnt == 0) bvalid = 1'b1;
      else b_cnt--;
    end else begin
      bvalid = 1'b0;
    end
    if (bvalid && bready) begin
      if (!(pend[last_served] && pend_write[last_served])) begin
        abort_run("Write response for a slot with no write in flight");
      end
      b_wait = 1'b0;
      pend[last_served] = 1'b0;
      done_ops++;
    end
    arready = arvalid && ar_cnt == 0;
    if (arvalid && ar_cnt != 0) ar_cnt--;
    if (arvalid && arready) begin
      r_exp[last_served] = amem[araddr[7:2]];
      r_wait = 1'b1;
      r_cnt = rand_below(4);
      ar_cnt = rand_below(4);
    end
    if (r_wait) begin
      if (r_cnt == 0) begin
        rvalid = 1'b1;
        rdata = r_exp[last_served];
      end else begin
        r_cnt--;
      end
    end else begin
      rvalid = 1'b0;
    end
    if (rvalid && rready) begin
      r_wait = 1'b0;
      rq.push_back(last_served);
    end
  endtask

  // Issue one operation on a free slice, updating the model as it is accepted
  task automatic drive_op();
    tawas_pkg::slice_t free_list [4];
    tawas_pkg::slice_t s;
    int nfree;
    int idx;
    nfree = 0;
    op_valid = 1'b0;
    for (int i = 0; i < 4; i++) begin
      if (!stall[i]) begin
        free_list[nfree] = tawas_pkg::slice_t'(i);
        nfree++;
      end
    end
    if (issued >= total_ops || nfree == 0) return;
    s = free_list[rand_below(nfree)];
    op_valid = 1'b1;
    op_slice = s;
    op_data = $random(seed);
    op_reg = tawas_pkg::reg_sel_t'(rand_below(8));
    if (issued < dram_words) begin
      // Preload every local word so later loads read defined data
      op_write = 1'b1;
      op_mask = 4'hf;
      op_addr = tawas_pkg::word_t'(issued * 4);
    end else begin
      op_write = rand_below(2) == 1;
      op_mask = tawas_pkg::mask_t'(rand_below(16));
      if (rand_below(3) == 0) begin
        op_addr = 32'h8000_0000 | tawas_pkg::word_t'((rand_below(16) * 4 + int'(s)) * 4);
      end else begin
        op_addr = tawas_pkg::word_t'(rand_below(dram_words) * 4);
      end
    end
    issued++;
    if (op_addr[31]) begin
      pend[s] = 1'b1;
      pend_write[s] = op_write;
      started[s] = 1'b0;
      pend_addr[s] = op_addr;
      pend_data[s] = op_data;
      pend_mask[s] = op_mask;
      pend_reg[s] = op_reg;
      acc_edge[s] = cyc + 1;
    end else begin
      idx = int'(op_addr[31:2]) % dram_words;
      if (op_write) begin
        lmem[idx] = merge_bytes(lmem[idx], op_data, op_mask);
        done_ops++;
      end else begin
        lq_due.push_back(cyc + 3);
        lq_slice.push_back(s);
        lq_reg.push_back(op_reg);
        lq_data.push_back(lmem[idx]);
      end
    end
  endtask

  initial begin
    tawas_pkg::word_t a;
    logic finished;
    op_valid = 1'b0;
    op_slice = '0;
    op_write = 1'b0;
    op_addr = '0;
    op_data = '0;
    op_mask = '0;
    op_reg = '0;
    awready = 1'b0;
    wready = 1'b0;
    arready = 1'b0;
    bvalid = 1'b0;
    rvalid = 1'b0;
    bresp = 2'b00;
    rresp = 2'b00;
    rdata = '0;
    pend = '0;
    pend_write = '0;
    started = '0;
    aw_have = 1'b0;
    w_have = 1'b0;
    b_wait = 1'b0;
    r_wait = 1'b0;
    addr_v_prev = 1'b0;
    last_served = tawas_pkg::slice_t'(3);
    aw_cnt = 0;
    w_cnt = 0;
    ar_cnt = 0;
    b_cnt = 0;
    r_cnt = 0;
    finished = 1'b0;
    for (int i = 0; i < 4; i++) stall_age[i] = 0;
    for (int i = 0; i < 64; i++) begin
      a = 32'h8000_0000 | tawas_pkg::word_t'(i * 4);
      amem[i] = a ^ {a[15:0], a[31:16]} ^ 32'h3c3c_c3c3;
    end

    for (int n = 0; n < 20 && rst !== 1'b0; n++) @(negedge clk);
    if (rst !== 1'b0) abort_run("Reset was never released");
    @(negedge clk);
    check_stall(4'b0000, stall);
    check_bit("load_valid", 1'b0, load_valid);
    check_bit("awvalid", 1'b0, awvalid);
    check_bit("wvalid", 1'b0, wvalid);
    check_bit("arvalid", 1'b0, arvalid);
    check_bit("bready", 1'b0, bready);
    check_bit("rready", 1'b0, rready);

    for (int n = 0; n < max_cycles && !finished; n++) begin
      @(negedge clk);
      check_results();
      drive_slave();
      drive_op();
      finished = done_ops == total_ops && pend == 4'b0000 && lq_due.size() == 0;
    end

    if (finished) begin
      $display("SIMULATION PASSED");
      $finish;
    end else begin
      $display("Timeout waiting for all operations to complete");
      $display("SIMULATION FAILED");
      $fatal(1, "timeout");
    end
  end
endmodule

/* tests/tb_clk.sv */
// Clock and reset source for the load/store testbench.
// 8 ns clock, reset held high for the first two rising edges.
module tb_clk (
  output logic clk,
  output logic rst
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
  end
endmodule

/* source/tawas_lsu.sv */
// Load/store unit top level for the barrel-threaded core. Plain ports for the
// operation input, per-slice stall, register writeback and AXI4-Lite master.
module tawas_lsu #(
  parameter int dram_words = 256
) (
  input  logic                              clk,
  input  logic                              rst,

  input  logic                              op_valid,
  input  tawas_pkg::slice_t                 op_slice,
  input  logic                              op_write,
  input  tawas_pkg::word_t                  op_addr,
  input  tawas_pkg::word_t                  op_data,
  input  tawas_pkg::mask_t                  op_mask,
  input  tawas_pkg::reg_sel_t               op_reg,

  output logic [tawas_pkg::num_slices-1:0]  stall,

  output logic                              load_valid,
  output tawas_pkg::slice_t                 load_slice,
  output tawas_pkg::reg_sel_t               load_reg,
  output tawas_pkg::word_t                  load_data,

  output tawas_pkg::word_t                  awaddr,
  output logic                              awvalid,
  input  logic                              awready,
  output tawas_pkg::word_t                  wdata,
  output tawas_pkg::mask_t                  wstrb,
  output logic                              wvalid,
  input  logic                              wready,
  input  logic [1:0]                        bresp,
  input  logic                              bvalid,
  output logic                              bready,
  output tawas_pkg::word_t                  araddr,
  output logic                              arvalid,
  input  logic                              arready,
  input  tawas_pkg::word_t                  rdata,
  input  logic [1:0]                        rresp,
  input  logic                              rvalid,
  output logic                              rready
);

  logic                           ram_en;
  logic                           ram_wr;
  logic [$clog2(dram_words)-1:0]  ram_idx;
  tawas_pkg::mask_t               ram_mask;
  tawas_pkg::word_t               ram_wdata;
  tawas_pkg::word_t               ram_rdata;

  logic                 loc_valid;
  tawas_pkg::slice_t    loc_slice;
  tawas_pkg::reg_sel_t  loc_reg;

  logic                 rd_valid;
  tawas_pkg::slice_t    rd_slice;
  tawas_pkg::reg_sel_t  rd_reg;
  tawas_pkg::word_t     rd_data;
  logic                 rd_full;

  tawas_ls_if ls_bus ();

  tawas_ls #(.dram_words(dram_words)) tawas_ls (
    .clk(clk), .rst(rst),
    .op_valid(op_valid), .op_slice(op_slice), .op_write(op_write),
    .op_addr(op_addr), .op_data(op_data), .op_mask(op_mask), .op_reg(op_reg),
    .stall(stall),
    .ls_bus(ls_bus.ls),
    .ram_en(ram_en), .ram_wr(ram_wr), .ram_idx(ram_idx),
    .ram_mask(ram_mask), .ram_wdata(ram_wdata),
    .loc_valid(loc_valid), .loc_slice(loc_slice), .loc_reg(loc_reg)
  );

  tawas_dram #(.dram_words(dram_words)) tawas_dram (
    .clk(clk),
    .en(ram_en), .wr(ram_wr), .idx(ram_idx),
    .mask(ram_mask), .wdata(ram_wdata), .rdata(ram_rdata)
  );

  tawas_axi tawas_axi (
    .clk(clk), .rst(rst),
    .ls_bus(ls_bus.axi), .stall(stall),
    .rd_valid(rd_valid), .rd_slice(rd_slice), .rd_reg(rd_reg),
    .rd_data(rd_data), .rd_full(rd_full),
    .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
    .bresp(bresp), .bvalid(bvalid), .bready(bready),
    .araddr(araddr), .arvalid(arvalid), .arready(arready),
    .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready)
  );

  tawas_ld_rtn tawas_ld_rtn (
    .clk(clk), .rst(rst),
    .loc_valid(loc_valid), .loc_slice(loc_slice), .loc_reg(loc_reg),
    .loc_data(ram_rdata),
    .rd_valid(rd_valid), .rd_slice(rd_slice), .rd_reg(rd_reg),
    .rd_data(rd_data), .rd_full(rd_full),
    .load_valid(load_valid), .load_slice(load_slice),
    .load_reg(load_reg), .load_data(load_data)
  );

endmodule

/* source/tawas_ld_rtn.sv */
// Load return arbiter. Merges local RAM loads and AXI read results onto the
// one registered writeback port, local loads first.
module tawas_ld_rtn (
  input  logic                 clk,
  input  logic                 rst,

  input  logic                 loc_valid,
  input  tawas_pkg::slice_t    loc_slice,
  input  tawas_pkg::reg_sel_t  loc_reg,
  input  tawas_pkg::word_t     loc_data,

  input  logic                 rd_valid,
  input  tawas_pkg::slice_t    rd_slice,
  input  tawas_pkg::reg_sel_t  rd_reg,
  input  tawas_pkg::word_t     rd_data,
  output logic                 rd_full,

  output logic                 load_valid,
  output tawas_pkg::slice_t    load_slice,
  output tawas_pkg::reg_sel_t  load_reg,
  output tawas_pkg::word_t     load_data
);

  logic                 buf_v;
  tawas_pkg::slice_t    buf_slice;
  tawas_pkg::reg_sel_t  buf_reg;
  tawas_pkg::word_t     buf_data;

  // The buffer stays occupied past this edge only when a local load blocks it
  assign rd_full = buf_v && loc_valid;

  always_ff @(posedge clk) begin
    if (rst) begin
      load_valid <= 1'b0;
      buf_v      <= 1'b0;
    end else begin
      load_valid <= loc_valid || buf_v;
      buf_v      <= rd_valid || (buf_v && loc_valid);
    end
  end

  always_ff @(posedge clk) begin
    if (loc_valid) begin
      load_slice <= loc_slice;
      load_reg   <= loc_reg;
      load_data  <= loc_data;
    end else begin
      load_slice <= buf_slice;
      load_reg   <= buf_reg;
      load_data  <= buf_data;
    end
    if (rd_valid) begin
      buf_slice <= rd_slice;
      buf_reg   <= rd_reg;
      buf_data  <= rd_data;
    end
  end

endmodule

/* source/tawas_axi.sv */
// AXI4-Lite master bridge. One request slot per slice and a round-robin pick
// feed a single engine that runs one transaction at a time.
module tawas_axi (
  input  logic                              clk,
  input  logic                              rst,

  tawas_ls_if.axi                           ls_bus,
  output logic [tawas_pkg::num_slices-1:0]  stall,

  output logic                              rd_valid,
  output tawas_pkg::slice_t                 rd_slice,
  output tawas_pkg::reg_sel_t               rd_reg,
  output tawas_pkg::word_t                  rd_data,
  input  logic                              rd_full,

  output tawas_pkg::word_t                  awaddr,
  output logic                              awvalid,
  input  logic                              awready,
  output tawas_pkg::word_t                  wdata,
  output tawas_pkg::mask_t                  wstrb,
  output logic                              wvalid,
  input  logic                              wready,
  input  logic [1:0]                        bresp,
  input  logic                              bvalid,
  output logic                              bready,
  output tawas_pkg::word_t                  araddr,
  output logic                              arvalid,
  input  logic                              arready,
  input  tawas_pkg::word_t                  rdata,
  input  logic [1:0]                        rresp,
  input  logic                              rvalid,
  output logic                              rready
);

  localparam int ns = tawas_pkg::num_slices;

  // Slot payloads
  logic                 slot_write [ns];
  tawas_pkg::word_t     slot_addr  [ns];
  tawas_pkg::word_t     slot_data  [ns];
  tawas_pkg::mask_t     slot_mask  [ns];
  tawas_pkg::reg_sel_t  slot_reg   [ns];

  logic [ns-1:0]          occ;
  logic [ns-1:0]          issued;
  tawas_pkg::slice_t      last_slice;
  tawas_pkg::arb_state_t  state;
  tawas_pkg::slice_t      cur;
  logic                   w_done;
  logic                   rtn_pend;
  tawas_pkg::slice_t      rtn_slice;
  logic                   pick_valid;
  tawas_pkg::slice_t      pick;

  // Round robin starting just after the slice served last
  always_comb begin
    tawas_pkg::slice_t cand;
    pick_valid = 1'b0;
    pick       = last_slice;
    for (int i = ns; i >= 1; i--) begin
      cand = tawas_pkg::slice_t'(last_slice + i);
      if (occ[cand] && !issued[cand]) begin
        pick_valid = 1'b1;
        pick       = cand;
      end
    end
  end

  // A slice stalls from the hand-off cycle until its slot is freed
  always_comb begin
    stall = occ;
    if (ls_bus.valid) begin
      stall[ls_bus.slice] = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (ls_bus.valid) begin
      slot_write[ls_bus.slice] <= ls_bus.write;
      slot_addr[ls_bus.slice]  <= ls_bus.addr;
      slot_data[ls_bus.slice]  <= ls_bus.data;
      slot_mask[ls_bus.slice]  <= ls_bus.mask;
      slot_reg[ls_bus.slice]   <= ls_bus.reg_sel;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= tawas_pkg::idle;
      occ        <= '0;
      issued     <= '0;
      last_slice <= tawas_pkg::slice_t'(ns - 1);
      w_done     <= 1'b0;
      rtn_pend   <= 1'b0;
    end else begin
      // Read slot is released once its buffered result reaches writeback
      if (rtn_pend && !rd_full) begin
        occ[rtn_slice]    <= 1'b0;
        issued[rtn_slice] <= 1'b0;
        rtn_pend          <= 1'b0;
      end
      case (state)
        tawas_pkg::idle: begin
          if (pick_valid) begin
            cur          <= pick;
            last_slice   <= pick;
            issued[pick] <= 1'b1;
            w_done       <= 1'b0;
            state        <= tawas_pkg::addr;
          end
        end
        tawas_pkg::addr: begin
          if (slot_write[cur]) begin
            if (awready) begin
              state <= (wready || w_done) ? tawas_pkg::resp : tawas_pkg::data;
            end else if (wready) begin
              w_done <= 1'b1;
            end
          end else if (arready) begin
            state <= tawas_pkg::resp;
          end
        end
        tawas_pkg::data: begin
          if (wready) begin
            state <= tawas_pkg::resp;
          end
        end
        tawas_pkg::resp: begin
          // Response codes are taken as they come, whatever bresp or rresp says
          if (bready && bvalid) begin
            occ[cur]    <= 1'b0;
            issued[cur] <= 1'b0;
            state       <= tawas_pkg::idle;
          end else if (rd_valid) begin
            rtn_pend  <= 1'b1;
            rtn_slice <= cur;
            state     <= tawas_pkg::idle;
          end
        end
        default: state <= tawas_pkg::idle;
      endcase
      if (ls_bus.valid) begin
        occ[ls_bus.slice] <= 1'b1;
      end
    end
  end

  // Channel drive from the slot being served
  assign awaddr  = slot_addr[cur];
  assign araddr  = slot_addr[cur];
  assign wdata   = slot_data[cur];
  assign wstrb   = slot_mask[cur];
  assign awvalid = (state == tawas_pkg::addr) && slot_write[cur];
  assign wvalid  = ((state == tawas_pkg::addr) && slot_write[cur] && !w_done) ||
                   (state == tawas_pkg::data);
  assign arvalid = (state == tawas_pkg::addr) && !slot_write[cur];
  assign bready  = (state == tawas_pkg::resp) && slot_write[cur];
  assign rready  = (state == tawas_pkg::resp) && !slot_write[cur] && !rd_full;

  assign rd_valid = rvalid && rready;
  assign rd_slice = cur;
  assign rd_reg   = slot_reg[cur];
  assign rd_data  = rdata;

  a_slot_free: assert property (
    @(posedge clk) disable iff (rst) ls_bus.valid |-> !occ[ls_bus.slice]
  ) else $error("hand-off to busy slot of slice %0d", ls_bus.slice);

endmodule

/* source/tawas_dram.sv */
// Local data RAM, single port, byte-masked writes and a registered read.
module tawas_dram #(
  parameter int dram_words = 256
) (
  input  logic                           clk,

  input  logic                           en,
  input  logic                           wr,
  input  logic [$clog2(dram_words)-1:0]  idx,
  input  tawas_pkg::mask_t               mask,
  input  tawas_pkg::word_t               wdata,
  output tawas_pkg::word_t               rdata
);

  tawas_pkg::word_t mem [dram_words];

  // Writes merge only the enabled bytes into the stored word
  always_ff @(posedge clk) begin
    if (en && wr) begin
      for (int b = 0; b < 4; b++) begin
        if (mask[b]) begin
          mem[idx][8*b +: 8] <= wdata[8*b +: 8];
        end
      end
    end
  end

  // Read data holds until the next read
  always_ff @(posedge clk) begin
    if (en && !wr) begin
      rdata <= mem[idx];
    end
  end

endmodule

/* source/tawas_ls.sv */
// Load/store front end. Registers each operation, then sends it either to the
// local data RAM or across to the AXI bridge depending on the address region.
module tawas_ls #(
  parameter int dram_words = 256
) (
  input  logic                                 clk,
  input  logic                                 rst,

  input  logic                                 op_valid,
  input  tawas_pkg::slice_t                    op_slice,
  input  logic                                 op_write,
  input  tawas_pkg::word_t                     op_addr,
  input  tawas_pkg::word_t                     op_data,
  input  tawas_pkg::mask_t                     op_mask,
  input  tawas_pkg::reg_sel_t                  op_reg,
  input  logic [tawas_pkg::num_slices-1:0]     stall,

  tawas_ls_if.ls                               ls_bus,

  output logic                                 ram_en,
  output logic                                 ram_wr,
  output logic [$clog2(dram_words)-1:0]        ram_idx,
  output tawas_pkg::mask_t                     ram_mask,
  output tawas_pkg::word_t                     ram_wdata,

  output logic                                 loc_valid,
  output tawas_pkg::slice_t                    loc_slice,
  output tawas_pkg::reg_sel_t                  loc_reg
);

  logic                 r_valid;
  tawas_pkg::slice_t    r_slice;
  logic                 r_write;
  tawas_pkg::word_t     r_addr;
  tawas_pkg::word_t     r_data;
  tawas_pkg::mask_t     r_mask;
  tawas_pkg::reg_sel_t  r_reg;
  logic                 r_axi;

  // Accept stage
  always_ff @(posedge clk) begin
    if (rst) begin
      r_valid <= 1'b0;
    end else begin
      r_valid <= op_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (op_valid) begin
      r_slice <= op_slice;
      r_write <= op_write;
      r_addr  <= op_addr;
      r_data  <= op_data;
      r_mask  <= op_mask;
      r_reg   <= op_reg;
    end
  end

  assign r_axi = tawas_pkg::is_axi(r_addr);

  // Local RAM access, one cycle after acceptance
  // The index wraps on the RAM depth, which is a power of two
  assign ram_en    = r_valid && !r_axi;
  assign ram_wr    = r_write;
  assign ram_idx   = r_addr[$clog2(dram_words)+1:2];
  assign ram_mask  = r_mask;
  assign ram_wdata = r_data;

  // Load tags follow the RAM read by one cycle so they meet the read data
  always_ff @(posedge clk) begin
    if (rst) begin
      loc_valid <= 1'b0;
    end else begin
      loc_valid <= ram_en && !r_write;
    end
  end

  always_ff @(posedge clk) begin
    loc_slice <= r_slice;
    loc_reg   <= r_reg;
  end

  // AXI-region operations go to the bridge slot of their slice
  assign ls_bus.valid   = r_valid && r_axi;
  assign ls_bus.slice   = r_slice;
  assign ls_bus.write   = r_write;
  assign ls_bus.addr    = r_addr;
  assign ls_bus.data    = r_data;
  assign ls_bus.mask    = r_mask;
  assign ls_bus.reg_sel = r_reg;

  // A stalled slice must not issue, or the bridge would see a second request
  a_no_op_when_stalled: assert property (
    @(posedge clk) disable iff (rst) op_valid |-> !stall[op_slice]
  ) else $error("operation issued on stalled slice %0d", op_slice);

endmodule

/* source/tawas_ls_if.sv */
// Hand-off of one AXI-region operation from the load/store front end to the
// AXI bridge. A hand-off lasts one cycle and the target slot is always free.
interface tawas_ls_if;

  logic                 valid;
  tawas_pkg::slice_t    slice;
  logic                 write;
  tawas_pkg::word_t     addr;
  tawas_pkg::word_t     data;
  tawas_pkg::mask_t     mask;
  tawas_pkg::reg_sel_t  reg_sel;

  modport ls (
    output valid,
    output slice,
    output write,
    output addr,
    output data,
    output mask,
    output reg_sel
  );

  modport axi (
    input valid,
    input slice,
    input write,
    input addr,
    input data,
    input mask,
    input reg_sel
  );

endinterface

/* source/tawas_pkg.sv */
// Shared widths, tag types and address-region rule for the load/store path.
// Every block refers to these by scoped name.
package tawas_pkg;

  // Number of barrel thread slices, fixed by the core pipeline
  localparam int num_slices = 4;

  // Addresses with this bit set belong to the AXI region
  localparam int axi_region_bit = 31;

  // Data or address word
  typedef logic [31:0] word_t;

  // Byte enables of one word
  typedef logic [3:0] mask_t;

  // Thread slice number
  typedef logic [$clog2(num_slices)-1:0] slice_t;

  // Destination register within a slice
  typedef logic [2:0] reg_sel_t;

  // AXI engine states
  typedef enum logic [1:0] {
    idle,
    addr,
    data,
    resp
  } arb_state_t;

  // True when the address is served by the AXI port instead of the local RAM
  function automatic logic is_axi(input word_t a);
    return a[axi_region_bit];
  endfunction

endpackage
